// ==== hw/viterbi_pkg.sv ====
// symbol and metric types plus decoder-wide constants, imported by the rtl and the testbench
package viterbi_pkg;

	// ====================
	// types
	// ====================

	// received rate 1/2 code symbol, one per clock
	// bit 0 = u ^ u(n-1) ^ u(n-2)
	// bit 1 = u ^ u(n-2)
	typedef logic [1:0] symbol_t;

	// hamming distance between two symbols, range 0..2
	typedef logic [1:0] branch_metric_t;

	// ====================
	// constants
	// ====================

	// constraint length 3 leaves two memory bits, hence four trellis states
	localparam int num_states = 4;

	// path metric width; all ones is the saturated (unreachable) value
	localparam int default_metric_width = 4;

	// register-exchange stages, roughly five constraint lengths
	localparam int default_survivor_depth = 15;

endpackage

// ==== hw/trellis_pkg.sv ====
// trellis state encoding and transition rules of the K=3 code, used by the rtl blocks
package trellis_pkg;

	// ====================
	// state encoding
	// ====================

	// state = {u(n-1), u(n-2)}, newest input bit in the msb
	typedef enum logic [1:0] {
		st_00 = 2'b00,
		st_01 = 2'b01,
		st_10 = 2'b10,
		st_11 = 2'b11
	} trellis_state_t;

	// ====================
	// transition rules
	// ====================

	// leaving state s with input u lands in {u, s[1]}
	// so state t is reached from {t[0], x} for x = 0 or 1
	// branch 0 is the predecessor with low bit 0
	function automatic trellis_state_t predecessor(trellis_state_t state, logic branch);
		predecessor = trellis_state_t'({state[0], branch});
	endfunction

	// symbol put out by the encoder when leaving pred with input in_bit
	// pred[1] is u(n-1), pred[0] is u(n-2)
	function automatic viterbi_pkg::symbol_t expected_symbol(trellis_state_t pred,
		logic in_bit);
		logic bit0;
		logic bit1;
		bit0 = in_bit ^ pred[1] ^ pred[0]; // generator 111
		bit1 = in_bit ^ pred[0]; // generator 101
		expected_symbol = {bit1, bit0};
	endfunction

	// decoded input bit implied by being in a state
	function automatic logic state_lead_bit(trellis_state_t state);
		state_lead_bit = state[1]; // most recent input bit
	endfunction

endpackage

// ==== hw/branch_metric_unit.sv ====
// branch metric unit: hamming distance of the received symbol to each of the eight transitions
`timescale 1ns/1ps

module branch_metric_unit (
	input viterbi_pkg::symbol_t cx, // received symbol
	output viterbi_pkg::branch_metric_t bm [viterbi_pkg::num_states][2] // [pred][input bit]
);

	import viterbi_pkg::*;
	import trellis_pkg::*;

	// ====================
	// distance per branch
	// ====================

	// one xor + popcount per (predecessor, input bit) pair
	for (genvar p = 0; p < num_states; p++)
	begin : g_pred
		for (genvar b = 0; b < 2; b++)
		begin : g_bit
			symbol_t diff; // bits where cx and the expected symbol disagree

			assign diff = cx ^ expected_symbol(trellis_state_t'(p), 1'(b));

			// two-bit popcount, fits the 0..2 range
			assign bm[p][b] = branch_metric_t'(diff[0]) + branch_metric_t'(diff[1]);
		end
	end

endmodule

// ==== hw/acs_unit.sv ====
// saturating add-compare-select for one trellis state, instantiated once per state
`timescale 1ns/1ps

module acs_unit #(
	parameter int metric_width = viterbi_pkg::default_metric_width
) (
	input logic [metric_width-1:0] pm_a, // path metric via branch 0
	input logic [metric_width-1:0] pm_b, // path metric via branch 1
	input viterbi_pkg::branch_metric_t bm_a, // branch metric for branch 0
	input viterbi_pkg::branch_metric_t bm_b, // branch metric for branch 1
	output logic [metric_width-1:0] new_pm, // survivor metric
	output logic decision // 0 = branch 0 won, 1 = branch 1 won
);

	// ====================
	// add
	// ====================

	// one spare bit catches the carry out
	logic [metric_width:0] sum_a_wide;
	logic [metric_width:0] sum_b_wide;
	logic [metric_width-1:0] sum_a; // saturated
	logic [metric_width-1:0] sum_b; // saturated

	assign sum_a_wide = {1'b0, pm_a} + (metric_width + 1)'(bm_a);
	assign sum_b_wide = {1'b0, pm_b} + (metric_width + 1)'(bm_b);

	// clamp at all ones on carry out
	assign sum_a = sum_a_wide[metric_width] ? '1 : sum_a_wide[metric_width-1:0];
	assign sum_b = sum_b_wide[metric_width] ? '1 : sum_b_wide[metric_width-1:0];

	// ====================
	// compare and select
	// ====================

	// ties go to branch 0
	assign decision = (sum_a <= sum_b) ? 1'b0 : 1'b1;
	assign new_pm = decision ? sum_b : sum_a;

endmodule

// ==== hw/best_state_finder.sv ====
// minimum search over the four path metrics, shared by the metric memory and the survivor decoder
`timescale 1ns/1ps

module best_state_finder #(
	parameter int metric_width = viterbi_pkg::default_metric_width
) (
	input logic [metric_width-1:0] metrics [viterbi_pkg::num_states],
	output trellis_pkg::trellis_state_t best_state, // lowest index among the minima
	output logic [metric_width-1:0] best_metric // the minimum itself
);

	import trellis_pkg::*;

	// first level winners
	trellis_state_t low_state; // winner of 0 vs 1
	trellis_state_t high_state; // winner of 2 vs 3
	logic [metric_width-1:0] low_metric;
	logic [metric_width-1:0] high_metric;

	// ====================
	// level 1
	// ====================

	// <= keeps the lower index on a tie
	assign low_state = (metrics[0] <= metrics[1]) ? st_00 : st_01;
	assign low_metric = (metrics[0] <= metrics[1]) ? metrics[0] : metrics[1];

	assign high_state = (metrics[2] <= metrics[3]) ? st_10 : st_11;
	assign high_metric = (metrics[2] <= metrics[3]) ? metrics[2] : metrics[3];

	// ====================
	// level 2
	// ====================

	// low pair wins ties again
	assign best_state = (low_metric <= high_metric) ? low_state : high_state;
	assign best_metric = (low_metric <= high_metric) ? low_metric : high_metric;

endmodule

// ==== hw/path_metric_memory.sv ====
// path metric register bank; renormalizes each new set against its minimum before storing it
`timescale 1ns/1ps

module path_metric_memory #(
	parameter int metric_width = viterbi_pkg::default_metric_width
) (
	input logic clk,
	input logic reset,
	input logic [metric_width-1:0] new_pm [viterbi_pkg::num_states], // from the acs units
	output logic [metric_width-1:0] pm [viterbi_pkg::num_states] // registered, normalized
);

	import viterbi_pkg::*;
	import trellis_pkg::*;

	logic [metric_width-1:0] min_pm; // smallest of the new metrics
	logic [metric_width-1:0] norm_pm [num_states]; // after subtracting min_pm

	// ====================
	// normalization
	// ====================

	// only the minimum is needed here, the state index is left open
	best_state_finder #(
		.metric_width(metric_width)
	) u_min (
		.metrics(new_pm),
		.best_state(),
		.best_metric(min_pm)
	);

	// best state always ends at 0, the rest stay relative to it
	// no underflow since min_pm <= every new_pm
	always_comb
	begin
		for (int s = 0; s < num_states; s++)
		begin
			norm_pm[s] = new_pm[s] - min_pm;
		end
	end

	// ====================
	// metric registers
	// ====================

	// reset forces the start in state 00; the others begin saturated
	// so the first steps cannot pick a false equal-cost path
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < num_states; s++)
			begin
				pm[s] <= (s == int'(st_00)) ? '0 : '1;
			end
		end
		else
		begin
			for (int s = 0; s < num_states; s++)
			begin
				pm[s] <= norm_pm[s];
			end
		end
	end

endmodule

// ==== hw/survivor_path_decoder.sv ====
// register-exchange survivor memory with final selection of the decoded bit at the best state
`timescale 1ns/1ps

module survivor_path_decoder #(
	parameter int metric_width = viterbi_pkg::default_metric_width,
	parameter int survivor_depth = viterbi_pkg::default_survivor_depth
) (
	input logic clk,
	input logic reset,
	input logic [viterbi_pkg::num_states-1:0] decision, // acs decisions, one per state
	input logic [metric_width-1:0] pm [viterbi_pkg::num_states], // current path metrics
	output logic decoded
);

	import viterbi_pkg::*;
	import trellis_pkg::*;

	trellis_state_t chosen_pred [num_states]; // survivor predecessor of each state
	trellis_state_t best_state; // state with the smallest path metric

	// surv[k][s] holds the bit k+1 steps back along the survivor into state s
	logic [num_states-1:0] surv [survivor_depth];

	// ====================
	// predecessor select
	// ====================

	// decision picks branch 0 or 1, which fixes the predecessor
	for (genvar s = 0; s < num_states; s++)
	begin : g_pred
		assign chosen_pred[s] = predecessor(trellis_state_t'(s), decision[s]);
	end

	// ====================
	// exchange chain
	// ====================

	// every stage copies its row from the chosen predecessor of each state,
	// stage 0 is seeded with the predecessor's own lead bit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < survivor_depth; k++)
			begin
				surv[k] <= '0; // decoded stays 0 until the chain refills
			end
		end
		else
		begin
			for (int s = 0; s < num_states; s++)
			begin
				surv[0][s] <= state_lead_bit(chosen_pred[s]); // seed
				for (int k = 1; k < survivor_depth; k++)
				begin
					surv[k][s] <= surv[k-1][chosen_pred[s]]; // follow the survivor
				end
			end
		end
	end

	// ====================
	// output select
	// ====================

	// trace from the most likely state; its metric value is not needed
	best_state_finder #(
		.metric_width(metric_width)
	) u_best (
		.metrics(pm),
		.best_state(best_state),
		.best_metric()
	);

	// combinational pick from the last stage
	assign decoded = surv[survivor_depth-1][best_state];

endmodule

// ==== hw/viterbi_decoder.sv ====
// top level of the K=3 rate 1/2 viterbi decoder; one symbol in and one decoded bit out per clock
`timescale 1ns/1ps

module viterbi_decoder #(
	parameter int metric_width = viterbi_pkg::default_metric_width,
	parameter int survivor_depth = viterbi_pkg::default_survivor_depth
) (
	input logic clk,
	input logic reset,
	input viterbi_pkg::symbol_t cx, // received symbol, may carry bit errors
	output logic decoded // input bit of the symbol sent survivor_depth + 1 cycles earlier
);

	import viterbi_pkg::*;
	import trellis_pkg::*;

	branch_metric_t bm [num_states][2]; // [pred][input bit]
	logic [metric_width-1:0] new_pm [num_states]; // acs results
	logic [metric_width-1:0] pm [num_states]; // stored, normalized metrics
	logic [num_states-1:0] decision; // acs branch choices

	// ====================
	// branch metrics
	// ====================

	branch_metric_unit u_bmu (
		.cx(cx),
		.bm(bm)
	);

	// ====================
	// acs array
	// ====================

	// state i is entered from pred_a (branch 0) or pred_b (branch 1),
	// both with the input bit that state i implies
	for (genvar i = 0; i < num_states; i++)
	begin : g_acs
		localparam trellis_state_t this_state = trellis_state_t'(i);
		localparam trellis_state_t pred_a = predecessor(this_state, 1'b0);
		localparam trellis_state_t pred_b = predecessor(this_state, 1'b1);
		localparam logic in_bit = state_lead_bit(this_state);

		acs_unit #(
			.metric_width(metric_width)
		) u_acs (
			.pm_a(pm[pred_a]),
			.pm_b(pm[pred_b]),
			.bm_a(bm[pred_a][in_bit]),
			.bm_b(bm[pred_b][in_bit]),
			.new_pm(new_pm[i]),
			.decision(decision[i])
		);
	end

	// ====================
	// metric memory
	// ====================

	path_metric_memory #(
		.metric_width(metric_width)
	) u_pmm (
		.clk(clk),
		.reset(reset),
		.new_pm(new_pm),
		.pm(pm)
	);

	// ====================
	// survivor path
	// ====================

	survivor_path_decoder #(
		.metric_width(metric_width),
		.survivor_depth(survivor_depth)
	) u_spd (
		.clk(clk),
		.reset(reset),
		.decision(decision),
		.pm(pm),
		.decoded(decoded)
	);

endmodule

// ==== bench/clock_gen.sv ====
// testbench clock and power-on reset source, instantiated once by the decoder testbench
`timescale 1ns/1ps

module clock_gen #(
	parameter int period_ns = 4, // full clock period
	parameter int reset_cycles = 2 // rising edges seen with reset high
) (
	output logic clk,
	output logic reset // power-on reset, active high
);

	// free running clock, first rising edge after half a period
	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	// release on a falling edge so the dut samples a clean level
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== bench/viterbi_decoder_tb.sv ====
// self-checking viterbi decoder testbench that runs as the simulation top level
`timescale 1ns/1ps

module viterbi_decoder_tb;

	import viterbi_pkg::*;

	localparam int latency = default_survivor_depth + 1; // symbol in to bit out
	localparam int max_cycles = 4096; // history depth
	localparam int run_limit = 3000; // watchdog limit in clock cycles
	localparam logic [31:0] lfsr_seed = 32'h652e_43e4;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	logic clk;
	logic por; // power-on reset
	logic mid_reset = 1'b0; // reset pulses from the stimulus
	logic reset;
	symbol_t cx;
	logic decoded;

	int cycle_no = 0; // index of the symbol taken at the next rising edge
	logic sent_bit [max_cycles]; // input bit behind each symbol
	logic sent_reset [max_cycles]; // reset level the dut saw at that edge
	string bit_test [max_cycles]; // test label per symbol
	logic [1:0] enc_state; // {u(n-1), u(n-2)}
	logic [31:0] lfsr;
	logic stim_done = 1'b0;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	assign reset = por | mid_reset;

	clock_gen #(
		.period_ns(4),
		.reset_cycles(2)
	) clk_src (
		.clk(clk),
		.reset(por)
	);

	viterbi_decoder #(
		.metric_width(default_metric_width),
		.survivor_depth(default_survivor_depth)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.cx(cx),
		.decoded(decoded)
	);

	// ====================
	// reference model
	// ====================

	// rate 1/2 encoder with taps 111 for bit 0 and 101 for bit 1
	function automatic symbol_t encode(logic u, logic [1:0] state);
		symbol_t sym;
		sym[0] = u ^ state[1] ^ state[0];
		sym[1] = u ^ state[0];
		return sym;
	endfunction

	// decoded bit while symbol c is on the input
	// a reset anywhere in the last latency edges forces 0
	function automatic logic expected_decoded(int c);
		logic exp_bit;
		exp_bit = 1'b0;
		if (c >= latency)
		begin
			exp_bit = sent_bit[c-latency];
			for (int j = c - latency; j < c; j++)
				if (sent_reset[j])
					exp_bit = 1'b0;
		end
		return exp_bit;
	endfunction

	// hand-worked symbols indexed by {u(n-1), u(n-2), u}
	function automatic symbol_t known_transition(int idx);
		case (idx)
			0: known_transition = 2'b00;
			1: known_transition = 2'b11;
			2: known_transition = 2'b11;
			3: known_transition = 2'b00;
			4: known_transition = 2'b01;
			5: known_transition = 2'b10;
			6: known_transition = 2'b10;
			default: known_transition = 2'b01;
		endcase
	endfunction

	// galois step shifts right and folds the taps in when the lsb drops out
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	task automatic random_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr); // one step per bit
	endtask

	// ====================
	// checks and report
	// ====================

	task automatic check_bit(string test, logic expected, logic actual);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAILED %s: expected %b, actual %b (cycle %0d)",
				test, expected, actual, cycle_no);
		end
	endtask

	task automatic check_symbol(string test, symbol_t expected, symbol_t actual);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAILED %s: expected %b, actual %b", test, expected, actual);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
	endtask

	task automatic abort_run(string why);
		other_errors++;
		$display("error: %s", why);
		report_counts();
		$display("Done: errors found");
		$finish;
	endtask

	// ====================
	// stimulus
	// ====================

	// one symbol per falling edge
	task automatic send_bit(string test, logic u, symbol_t flip, logic rst);
		@(negedge clk);
		if (sent_reset[cycle_no-1]) // dut went back to state 00
			enc_state = 2'b00;
		else
			enc_state = {sent_bit[cycle_no-1], enc_state[1]};
		mid_reset = rst;
		cx = encode(u, enc_state) ^ flip; // flip marks channel errors
		sent_bit[cycle_no] = u;
		bit_test[cycle_no] = test;
	endtask

	// spacing 0 means no errors
	// double puts both bits of a symbol in error
	task automatic send_stream(string test, int count, int spacing, logic double,
		logic random_data, logic value);
		logic u;
		logic lane;
		symbol_t flip;
		for (int i = 0; i < count; i++)
		begin
			u = value;
			if (random_data)
				random_bit(u);
			flip = 2'b00;
			if (spacing > 0 && i % spacing == spacing - 1)
			begin
				random_bit(lane); // which bit takes a single error
				flip = double ? 2'b11 : (lane ? 2'b10 : 2'b01);
			end
			send_bit(test, u, flip, 1'b0);
		end
	endtask

	// edge bookkeeping that is read only on falling edges
	always @(posedge clk)
	begin
		sent_reset[cycle_no] = reset;
		cycle_no = cycle_no + 1;
	end

	// compare on falling edges since decoded only moves on rising edges
	initial
	begin : compare_decoded
		int c;
		string label;
		@(posedge clk); // dut state is undefined before the first edge
		forever
		begin
			@(negedge clk);
			c = cycle_no;
			label = (c >= latency) ? bit_test[c-latency] : "startup";
			check_bit(label, expected_decoded(c), decoded);
		end
	end

	initial
	begin : watchdog
		int n;
		n = 0;
		while (!stim_done && n < run_limit)
		begin
			@(posedge clk);
			n++;
		end
		if (!stim_done)
			abort_run("stimulus still running at the cycle limit");
	end

	initial
	begin : stimulus
		int n;
		cx = 2'b00;
		enc_state = 2'b00;
		lfsr = lfsr_seed;
		sent_bit[0] = 1'b0;
		bit_test[0] = "startup";

		// testbench encoder against the hand table
		for (int i = 0; i < 8; i++)
			check_symbol("encoder_table", known_transition(i), encode(i[0], 2'(i >> 1)));

		// symbol 0 is the idle value set above
		@(posedge clk);

		// idle symbols until an edge sees reset low
		send_bit("startup", 1'b0, 2'b00, 1'b0);
		for (n = 0; n < 20 && sent_reset[cycle_no-1]; n++)
			send_bit("startup", 1'b0, 2'b00, 1'b0);
		if (sent_reset[cycle_no-1])
			abort_run("reset was never released");
		else
		begin
			send_stream("random_clean", 400, 0, 1'b0, 1'b1, 1'b0);

			// mid stream reset restarts the output from zero
			send_bit("mid_reset", 1'b1, 2'b00, 1'b1);
			send_bit("mid_reset", 1'b1, 2'b00, 1'b1);
			send_stream("after_reset", 80, 0, 1'b0, 1'b1, 1'b0);

			send_stream("single_flip", 300, 25, 1'b0, 1'b1, 1'b0);
			send_stream("double_flip", 250, 25, 1'b1, 1'b1, 1'b0);

			// constant data keeps metrics saturated and renormalizing
			send_stream("ones_run", 200, 40, 1'b0, 1'b0, 1'b1);
			send_stream("zeros_run", 200, 40, 1'b0, 1'b0, 1'b0);

			send_stream("flush", latency + 4, 0, 1'b0, 1'b1, 1'b0);
			stim_done = 1'b1;
			@(posedge clk); // last compare is done by now

			report_counts();
			if (value_errors == 0 && other_errors == 0 && checks > 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
hw/viterbi_pkg.sv
hw/trellis_pkg.sv
hw/branch_metric_unit.sv
hw/acs_unit.sv
hw/best_state_finder.sv
hw/path_metric_memory.sv
hw/survivor_path_decoder.sv
hw/viterbi_decoder.sv
bench/clock_gen.sv
bench/viterbi_decoder_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the viterbi decoder testbench with verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	--top-module viterbi_decoder_tb \
	-f flist.f \
	-Mdir obj_dir

./obj_dir/Vviterbi_decoder_tb > sim.log 2>&1
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
